/* src/cpuPkg.sv */
// Shared definitions for the MEM/WB back end.
// Word, register-index and data-memory widths and depths.
// Write-back source select, load type and store type enums.

package cpuPkg;

    // data and address word width.
    localparam int DataWidth = 32;

    // bytes in one data word.
    localparam int ByteLanes = DataWidth / 8;

    // register index width and register count.
    localparam int RegAddrWidth = 5;
    localparam int RegCount = 1 << RegAddrWidth;

    // data memory is word addressed, 256 words.
    localparam int DmemAddrWidth = 8;
    localparam int DmemDepth = 1 << DmemAddrWidth;

    // write-back source, in the order of the result mux inputs.
    typedef enum logic [1:0] {
        SelPc8  = 2'd0,
        SelAlu  = 2'd1,
        SelOutB = 2'd2,
        SelDm   = 2'd3
    } WbSelType;

    // load width and extension.
    typedef enum logic [2:0] {
        LoadNone = 3'd0,
        LoadB    = 3'd1,
        LoadBu   = 3'd2,
        LoadH    = 3'd3,
        LoadHu   = 3'd4,
        LoadW    = 3'd5
    } LoadType;

    // store width.
    typedef enum logic [1:0] {
        StoreNone = 2'd0,
        StoreB    = 2'd1,
        StoreW    = 2'd2
    } StoreType;

endpackage

/* src/loadExtend.sv */
// Load data extension for the write-back stage.
// Byte and halfword selection by address offset, then sign or zero extension.

`timescale 1ns/1ns

module loadExtend (
    input  logic [cpuPkg::DataWidth-1:0]  dmOut,
    input  logic [1:0]                    byteAddr,
    input  cpuPkg::LoadType               loadType,
    output logic [cpuPkg::DataWidth-1:0]  dmResult
);
    import cpuPkg::*;

    logic [DataWidth-1:0]  shifted;
    logic [7:0]            loadByte;
    logic [15:0]           loadHalf;

    // move the addressed byte down to bit 0.
    assign shifted  = dmOut >> {byteAddr, 3'b000};
    assign loadByte = shifted[7:0];

    // halfwords are aligned, only bit 1 of the address matters.
    assign loadHalf = byteAddr[1] ? dmOut[31:16] : dmOut[15:0];

    always_comb begin
        case (loadType)
            LoadB: begin
                dmResult = {{(DataWidth-8){loadByte[7]}}, loadByte};
            end
            LoadBu: begin
                dmResult = {{(DataWidth-8){1'b0}}, loadByte};
            end
            LoadH: begin
                dmResult = {{(DataWidth-16){loadHalf[15]}}, loadHalf};
            end
            LoadHu: begin
                dmResult = {{(DataWidth-16){1'b0}}, loadHalf};
            end
            // full word, also what a non-load sees.
            default: begin
                dmResult = dmOut;
            end
        endcase
    end

endmodule

/* src/memStage.sv */
// Memory-access stage.
// MEM pipeline register, synchronous data memory with word and byte
// stores, and the load data register that moves with the WB stage.

`timescale 1ns/1ns

module memStage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             hold,
    input  logic [cpuPkg::DataWidth-1:0]     exAluOut,
    input  logic [cpuPkg::DataWidth-1:0]     exOutB,
    input  logic [cpuPkg::DataWidth-1:0]     exPc,
    input  logic [cpuPkg::RegAddrWidth-1:0]  exDst,
    input  logic                             exRegWr,
    input  cpuPkg::WbSelType                 exWbSel,
    input  cpuPkg::LoadType                  exLoadType,
    input  cpuPkg::StoreType                 exStoreType,
    output logic [cpuPkg::DataWidth-1:0]     memAluOut,
    output logic [cpuPkg::DataWidth-1:0]     memOutB,
    output logic [cpuPkg::DataWidth-1:0]     memPc,
    output logic [cpuPkg::RegAddrWidth-1:0]  memDst,
    output logic                             memRegWr,
    output cpuPkg::WbSelType                 memWbSel,
    output cpuPkg::LoadType                  memLoadType,
    output logic [cpuPkg::DataWidth-1:0]     dmOut
);
    import cpuPkg::*;

    StoreType                   memStoreType;
    logic [DataWidth-1:0]       dmem [0:DmemDepth-1];
    logic [DmemAddrWidth-1:0]   dmWordAddr;
    logic [ByteLanes-1:0]       byteEn;
    logic [DataWidth-1:0]       storeData;

    // control fields of the MEM register.
    always_ff @(posedge clk) begin
        if (rst) begin
            memRegWr     <= 1'b0;
            memLoadType  <= LoadNone;
            memStoreType <= StoreNone;
        end else if (!hold) begin
            memRegWr     <= exRegWr;
            memLoadType  <= exLoadType;
            memStoreType <= exStoreType;
        end
    end

    // payload fields.
    always_ff @(posedge clk) begin
        if (!hold) begin
            memAluOut <= exAluOut;
            memOutB   <= exOutB;
            memPc     <= exPc;
            memDst    <= exDst;
            memWbSel  <= exWbSel;
        end
    end

    assign dmWordAddr = memAluOut[DmemAddrWidth+1:2];

    // byte lane enables and store data, byte stores replicate the low byte.
    always_comb begin
        byteEn    = '0;
        storeData = memOutB;
        case (memStoreType)
            StoreW: byteEn = '1;
            StoreB: begin
                byteEn    = ByteLanes'(1) << memAluOut[1:0];
                storeData = {ByteLanes{memOutB[7:0]}};
            end
            default: byteEn = '0;
        endcase
    end

    // read happens before the write at the same edge.
    always_ff @(posedge clk) begin
        if (!hold) begin
            dmOut <= dmem[dmWordAddr];
            for (int i = 0; i < ByteLanes; i++) begin
                if (byteEn[i] && !rst) begin
                    dmem[dmWordAddr][8*i +: 8] <= storeData[8*i +: 8];
                end
            end
        end
    end

    // an instruction is either a load or a store, never both.
    storeNotLoad: assert property (@(posedge clk) disable iff (rst)
        (memStoreType != StoreNone) |-> (memLoadType == LoadNone));

endmodule

/* src/wbStage.sv */
// Write-back stage.
// WB pipeline register with flush and hold, load extension,
// four-way result selector and the gated register-file write strobe.

`timescale 1ns/1ns

module wbStage (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             hold,
    input  logic                             wbFlush,
    input  logic                             wbDisWr,
    input  logic [cpuPkg::DataWidth-1:0]     memAluOut,
    input  logic [cpuPkg::DataWidth-1:0]     memOutB,
    input  logic [cpuPkg::DataWidth-1:0]     memPc,
    input  logic [cpuPkg::RegAddrWidth-1:0]  memDst,
    input  logic                             memRegWr,
    input  cpuPkg::WbSelType                 memWbSel,
    input  cpuPkg::LoadType                  memLoadType,
    input  logic [cpuPkg::DataWidth-1:0]     dmOut,
    output logic [cpuPkg::DataWidth-1:0]     wbResult,
    output logic [cpuPkg::RegAddrWidth-1:0]  wbDst,
    output logic                             wbFinalWr
);
    import cpuPkg::*;

    logic [DataWidth-1:0]  wbAluOut;
    logic [DataWidth-1:0]  wbOutB;
    logic [DataWidth-1:0]  wbPc;
    logic                  wbRegWr;
    WbSelType              wbWbSel;
    LoadType               wbLoadType;
    logic [DataWidth-1:0]  wbDmResult;

    // flush takes priority over hold.
    always_ff @(posedge clk) begin
        if (rst || wbFlush) begin
            wbRegWr <= 1'b0;
        end else if (!hold) begin
            wbRegWr <= memRegWr;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wbAluOut   <= memAluOut;
            wbOutB     <= memOutB;
            wbPc       <= memPc;
            wbDst      <= memDst;
            wbWbSel    <= memWbSel;
            wbLoadType <= memLoadType;
        end
    end

    // dmOut is already aligned with this register.
    loadExtend uExt (
        .dmOut    (dmOut),
        .byteAddr (wbAluOut[1:0]),
        .loadType (wbLoadType),
        .dmResult (wbDmResult)
    );

    always_comb begin
        case (wbWbSel)
            SelPc8:  wbResult = wbPc + DataWidth'(8);
            SelAlu:  wbResult = wbAluOut;
            SelOutB: wbResult = wbOutB;
            default: wbResult = wbDmResult;
        endcase
    end

    // keep the result out of the register file while writes are disabled.
    assign wbFinalWr = wbRegWr && !wbDisWr;

    noWriteWhenDisabled: assert property (@(posedge clk) disable iff (rst)
        wbDisWr |-> !wbFinalWr);

endmodule

/* src/regFile.sv */
// Integer register file.
// 32 x 32 registers, register 0 reads as zero,
// one synchronous write port and one asynchronous read port.

`timescale 1ns/1ns

module regFile (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             wrEn,
    input  logic [cpuPkg::RegAddrWidth-1:0]  wrAddr,
    input  logic [cpuPkg::DataWidth-1:0]     wrData,
    input  logic [cpuPkg::RegAddrWidth-1:0]  rdAddr,
    output logic [cpuPkg::DataWidth-1:0]     rdData
);
    import cpuPkg::*;

    logic [DataWidth-1:0]  regs [0:RegCount-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // decode-stage read port.
    assign rdData = regs[rdAddr];

    // register 0 keeps its reset value since writes to it are dropped.
    zeroRegReadsZero: assert property (@(posedge clk) disable iff (rst)
        (rdAddr == '0) |-> (rdData == '0));

endmodule

/* src/memWbPipe.sv */
// Back-end top level.
// Memory stage, write-back stage and register file wired together.

`timescale 1ns/1ns

module memWbPipe (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             hold,
    input  logic                             wbFlush,
    input  logic                             wbDisWr,
    input  logic [cpuPkg::DataWidth-1:0]     exAluOut,
    input  logic [cpuPkg::DataWidth-1:0]     exOutB,
    input  logic [cpuPkg::DataWidth-1:0]     exPc,
    input  logic [cpuPkg::RegAddrWidth-1:0]  exDst,
    input  logic                             exRegWr,
    input  cpuPkg::WbSelType                 exWbSel,
    input  cpuPkg::LoadType                  exLoadType,
    input  cpuPkg::StoreType                 exStoreType,
    input  logic [cpuPkg::RegAddrWidth-1:0]  rdAddr,
    output logic [cpuPkg::DataWidth-1:0]     wbResult,
    output logic [cpuPkg::RegAddrWidth-1:0]  wbDst,
    output logic                             wbFinalWr,
    output logic [cpuPkg::DataWidth-1:0]     rdData
);
    import cpuPkg::*;

    logic [DataWidth-1:0]     memAluOut;
    logic [DataWidth-1:0]     memOutB;
    logic [DataWidth-1:0]     memPc;
    logic [RegAddrWidth-1:0]  memDst;
    logic                     memRegWr;
    WbSelType                 memWbSel;
    LoadType                  memLoadType;
    logic [DataWidth-1:0]     dmOut;

    memStage uMem (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .exAluOut    (exAluOut),
        .exOutB      (exOutB),
        .exPc        (exPc),
        .exDst       (exDst),
        .exRegWr     (exRegWr),
        .exWbSel     (exWbSel),
        .exLoadType  (exLoadType),
        .exStoreType (exStoreType),
        .memAluOut   (memAluOut),
        .memOutB     (memOutB),
        .memPc       (memPc),
        .memDst      (memDst),
        .memRegWr    (memRegWr),
        .memWbSel    (memWbSel),
        .memLoadType (memLoadType),
        .dmOut       (dmOut)
    );

    wbStage uWb (
        .clk         (clk),
        .rst         (rst),
        .hold        (hold),
        .wbFlush     (wbFlush),
        .wbDisWr     (wbDisWr),
        .memAluOut   (memAluOut),
        .memOutB     (memOutB),
        .memPc       (memPc),
        .memDst      (memDst),
        .memRegWr    (memRegWr),
        .memWbSel    (memWbSel),
        .memLoadType (memLoadType),
        .dmOut       (dmOut),
        .wbResult    (wbResult),
        .wbDst       (wbDst),
        .wbFinalWr   (wbFinalWr)
    );

    // written from the WB register even while hold is high.
    regFile uRegs (
        .clk    (clk),
        .rst    (rst),
        .wrEn   (wbFinalWr),
        .wrAddr (wbDst),
        .wrData (wbResult),
        .rdAddr (rdAddr),
        .rdData (rdData)
    );

endmodule

/* tb/tbMemWbPipe.sv */
// Testbench for the MEM/WB back end.
// Clock, reset, directed and random stimulus, a reference model of the
// pipeline registers, data memory and register file, concurrent checks,
// per-test reporting and a watchdog.

`timescale 1ns/1ns

module tbMemWbPipe;
    import cpuPkg::*;

    localparam int ClkPeriod = 40;
    localparam int ResetCycles = 8;
    localparam int RandCount = 24;
    localparam int LoadRounds = 3;
    // cycles issued by all tests, each register scan takes RegCount cycles.
    localparam int RunCycles = ResetCycles + 4 * RegCount + RandCount + LoadRounds * 26 + 24;

    logic                     clk;
    logic                     rst;
    logic                     hold;
    logic                     wbFlush;
    logic                     wbDisWr;
    logic [DataWidth-1:0]     exAluOut, exOutB, exPc;
    logic [RegAddrWidth-1:0]  exDst;
    logic                     exRegWr;
    WbSelType                 exWbSel;
    LoadType                  exLoadType;
    StoreType                 exStoreType;
    logic [RegAddrWidth-1:0]  rdAddr;
    logic [DataWidth-1:0]     wbResult;
    logic [RegAddrWidth-1:0]  wbDst;
    logic                     wbFinalWr;
    logic [DataWidth-1:0]     rdData;

    // reference model state.
    logic [DataWidth-1:0]     modelRegs [0:RegCount-1];
    logic [DataWidth-1:0]     modelMem [0:DmemDepth-1];
    logic [DataWidth-1:0]     nextRes, expMemRes, expWbRes;
    logic [RegAddrWidth-1:0]  nextDst, expMemDst, expWbDst, lastWrDst, scanAddr;
    logic                     nextWr, expMemWr, expWbWr;
    int                       errCount, errAtStart, testCount, failedTests;

    memWbPipe uut (.*);

    initial begin
        clk = 1'b0;
        forever #(ClkPeriod / 2) clk = ~clk;
    end

    // two-entry queue of expected results, moved by the same hold and flush rules.
    always @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < RegCount; i++) begin
                modelRegs[i] <= '0;
            end
        end else if (expWbWr && !wbDisWr) begin
            if (expWbDst != '0) begin
                modelRegs[expWbDst] <= expWbRes;
            end
            lastWrDst <= expWbDst;
        end
        if (rst || wbFlush) begin
            expWbWr <= 1'b0;
        end else if (!hold) begin
            expWbWr <= expMemWr;
        end
        if (rst) begin
            expMemWr <= 1'b0;
        end else if (!hold) begin
            expMemWr <= nextWr;
        end
        if (!hold) begin
            expWbRes  <= expMemRes;
            expWbDst  <= expMemDst;
            expMemRes <= nextRes;
            expMemDst <= nextDst;
        end
    end

    function automatic logic [DataWidth-1:0] extendLoad(logic [DataWidth-1:0] word,
                                                         logic [1:0] off, LoadType ld);
        logic [7:0]   b;
        logic [15:0]  h;
        b = word[8*off +: 8];
        h = off[1] ? word[31:16] : word[15:0];
        case (ld)
            LoadB:   return {{24{b[7]}}, b};
            LoadBu:  return {24'd0, b};
            LoadH:   return {{16{h[15]}}, h};
            LoadHu:  return {16'd0, h};
            default: return word;
        endcase
    endfunction

    task automatic noteError(string name, logic [DataWidth-1:0] got, logic [DataWidth-1:0] exp);
        errCount++;
        $display("ERROR %s: got 0x%h, expected 0x%h at %0t ns", name, got, exp, $time);
    endtask

    // one instruction per call, the model is updated in program order.
    task automatic issue(input logic [DataWidth-1:0] alu, outB, pc,
                         input logic [RegAddrWidth-1:0] dst, input logic wr,
                         input WbSelType sel, input LoadType ld = LoadNone,
                         input StoreType st = StoreNone);
        logic [DmemAddrWidth-1:0] idx;
        @(posedge clk);
        #5;
        idx = alu[DmemAddrWidth+1:2];
        exAluOut    = alu;
        exOutB      = outB;
        exPc        = pc;
        exDst       = dst;
        exRegWr     = wr;
        exWbSel     = sel;
        exLoadType  = ld;
        exStoreType = st;
        rdAddr      = lastWrDst;
        case (st)
            StoreW:  modelMem[idx] = outB;
            StoreB:  modelMem[idx][8*alu[1:0] +: 8] = outB[7:0];
            default: ;
        endcase
        case (sel)
            SelPc8:  nextRes = pc + 32'd8;
            SelAlu:  nextRes = alu;
            SelOutB: nextRes = outB;
            default: nextRes = extendLoad(modelMem[idx], alu[1:0], ld);
        endcase
        nextDst = dst;
        nextWr  = wr;
    endtask

    // inputs stay as they are, the read port walks through the registers.
    task automatic waitCycles(int n);
        repeat (n) begin
            @(posedge clk);
            #5;
            rdAddr = scanAddr;
            scanAddr++;
        end
    endtask

    task automatic finishTest(string name);
        testCount++;
        if (errCount == errAtStart) begin
            $display("test %0d %s: ok", testCount, name);
        end else begin
            failedTests++;
            $display("test %0d %s: %0d errors", testCount, name, errCount - errAtStart);
        end
        errAtStart = errCount;
    endtask

    chkFinalWr: assert property (@(posedge clk) disable iff (rst)
        wbFinalWr == (expWbWr && !wbDisWr))
        else noteError("wbFinalWr", $sampled(wbFinalWr), $sampled(expWbWr && !wbDisWr));
    chkResult: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(expWbRes) |-> wbResult == expWbRes)
        else noteError("wbResult", $sampled(wbResult), $sampled(expWbRes));
    chkDst: assert property (@(posedge clk) disable iff (rst)
        !$isunknown(expWbDst) |-> wbDst == expWbDst)
        else noteError("wbDst", $sampled(wbDst), $sampled(expWbDst));
    chkReadBack: assert property (@(posedge clk) disable iff (rst)
        rdData == modelRegs[rdAddr])
        else noteError("rdData", $sampled(rdData), $sampled(modelRegs[rdAddr]));
    chkHoldStable: assert property (@(posedge clk) disable iff (rst)
        (hold && !wbFlush) |=> ($stable(wbResult) && $stable(wbDst)))
        else begin
            errCount++;
            $display("hold did not keep wbResult and wbDst constant at %0t ns", $time);
        end

    initial begin
        logic [DataWidth-1:0] base;
        void'($urandom(660));
        {errCount, errAtStart, testCount, failedTests} = '0;
        {exAluOut, exOutB, exPc, exDst, exRegWr, rdAddr} = '0;
        {hold, wbFlush, wbDisWr, lastWrDst, scanAddr} = '0;
        exWbSel     = SelAlu;
        exLoadType  = LoadNone;
        exStoreType = StoreNone;
        {nextRes, nextDst, nextWr} = '0;
        rst = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #5;
        rst = 1'b0;

        waitCycles(RegCount);
        finishTest("reset state");

        issue($urandom, $urandom, $urandom, 5'd0, 1'b1, SelAlu);
        for (int i = 0; i < RandCount; i++) begin
            issue($urandom, $urandom, $urandom, 5'($urandom), 1'b1,
                  WbSelType'($urandom_range(0, 2)));
        end
        finishTest("alu, move and pc+8 results");

        for (int r = 0; r < LoadRounds; r++) begin
            base = {$urandom} & 32'hffff_fffc;
            issue(base, $urandom, 0, 0, 1'b0, SelAlu, LoadNone, StoreW);
            issue(base + $urandom_range(0, 3), $urandom, 0, 0, 1'b0, SelAlu, LoadNone, StoreB);
            for (int off = 0; off < 4; off++) begin
                for (int k = LoadNone; k <= LoadW; k++) begin
                    issue(base + off, 0, 0, 5'($urandom_range(1, 31)), 1'b1, SelDm, LoadType'(k));
                end
            end
        end
        finishTest("stores and extended loads");

        // the first instruction is flushed as it enters WB.
        issue($urandom, 0, 0, 5'd7, 1'b1, SelAlu);
        issue($urandom, 0, 0, 5'd8, 1'b1, SelAlu);
        wbFlush = 1'b1;
        issue(0, 0, 0, 0, 1'b0, SelAlu);
        wbFlush = 1'b0;
        waitCycles(RegCount);
        finishTest("write-back flush");

        issue($urandom, 0, 0, 5'd9, 1'b1, SelAlu);
        issue(0, 0, 0, 0, 1'b0, SelAlu);
        issue(0, 0, 0, 0, 1'b0, SelAlu);
        hold    = 1'b1;
        wbDisWr = 1'b1;
        waitCycles(3);
        wbDisWr = 1'b0;
        waitCycles(1);
        hold = 1'b0;
        waitCycles(RegCount);
        finishTest("write disable");

        // a load of the word waits in WB while the second store to it sits in MEM.
        base = {$urandom} & 32'hffff_fffc;
        issue(base, $urandom, 0, 0, 1'b0, SelAlu, LoadNone, StoreW);
        issue(base, 0, 0, 5'd13, 1'b1, SelDm, LoadW);
        issue(base, $urandom, 0, 0, 1'b0, SelAlu, LoadNone, StoreW);
        issue($urandom, $urandom, $urandom, 5'd10, 1'b1, SelPc8);
        hold = 1'b1;
        waitCycles(4);
        hold = 1'b0;
        issue(base, 0, 0, 5'd11, 1'b1, SelDm, LoadW);
        issue($urandom, $urandom, 0, 5'd12, 1'b1, SelOutB);
        issue(0, 0, 0, 0, 1'b0, SelAlu);
        waitCycles(RegCount);
        finishTest("hold in a stream");

        $display("tests run: %0d, tests failed: %0d, errors: %0d",
                 testCount, failedTests, errCount);
        if (errCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        #((RunCycles + 64) * ClkPeriod);
        $display("watchdog: the run did not end within %0d cycles", RunCycles + 64);
        $display("Result: FAILED");
        $finish;
    end

endmodule

/* vlog.f */
src/cpuPkg.sv
src/loadExtend.sv
src/memStage.sv
src/wbStage.sv
src/regFile.sv
src/memWbPipe.sv
tb/tbMemWbPipe.sv
